// File: include/execPort_consts.svh
`ifndef EXEC_PORT_CONSTS_SVH
`define EXEC_PORT_CONSTS_SVH

// ------------------------------
// widths and sizes
// ------------------------------
`define EXEC_DATA_W     32
`define EXEC_TAG_W      6
`define EXEC_NUM_REGS   64
`define EXEC_IQ_DEPTH   8
`define EXEC_OP_W       3
`define EXEC_DIV_STEPS  32

// ------------------------------
// micro-op opcodes
// ------------------------------
`define OP_ADDI  3'd0
`define OP_ADD   3'd1
`define OP_SUB   3'd2
`define OP_AND   3'd3
`define OP_XOR   3'd4
`define OP_DIVU  3'd5
`define OP_REMU  3'd6

`endif

// File: design/execPkg.sv
`include "execPort_consts.svh"

package execPkg;

    // ------------------------------
    // datapath
    // ------------------------------
    typedef logic [`EXEC_DATA_W-1:0] dataT;
    typedef logic [`EXEC_TAG_W-1:0]  tagT;   // physical register tag
    typedef logic [`EXEC_OP_W-1:0]   opcodeT;

    // ------------------------------
    // issue queue bookkeeping
    // ------------------------------
    typedef logic [$clog2(`EXEC_IQ_DEPTH)-1:0] iqPtrT;

    // one extra bit so a full queue / full credit pool fits
    typedef logic [$clog2(`EXEC_IQ_DEPTH+1)-1:0] creditT;

    // ------------------------------
    // divider
    // ------------------------------
    typedef logic [$clog2(`EXEC_DIV_STEPS+1)-1:0] divCountT;

    typedef enum logic [1:0] {
        IDLE,   // waiting for a divide
        RUN,    // shift-subtract steps
        DONE    // result held until granted
    } divStateT;

endpackage

// File: design/execIssueIf.sv
interface execIssueIf import execPkg::*;
();
    logic   valid;
    opcodeT op;
    tagT    dstTag;
    dataT   opA;
    dataT   opB;    // immediate for addi

    modport source (
        output valid, op, dstTag, opA, opB
    );

    modport sink (
        input valid, op, dstTag, opA, opB
    );

endinterface

// File: design/issueQueue.sv
`include "execPort_consts.svh"

module issueQueue import execPkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic   dispValid,
    input  opcodeT dispOp,
    input  tagT    dispDst,
    input  tagT    dispSrcA,
    input  tagT    dispSrcB,
    input  dataT   dispImm,
    output logic   creditReturn,

    output tagT  rdAddrA,
    output tagT  rdAddrB,
    input  dataT rdDataA,
    input  dataT rdDataB,
    input  logic [`EXEC_NUM_REGS-1:0] srcReady,
    output logic clearValid,
    output tagT  clearTag,

    input  logic divBusy,
    execIssueIf.source issue
);

opcodeT qOp   [`EXEC_IQ_DEPTH];
tagT    qDst  [`EXEC_IQ_DEPTH];
tagT    qSrcA [`EXEC_IQ_DEPTH];
tagT    qSrcB [`EXEC_IQ_DEPTH];
dataT   qImm  [`EXEC_IQ_DEPTH];

iqPtrT  head, tail;     // depth is a power of two, pointers wrap on their own
creditT count;

logic   issueValid;
opcodeT issueOp;
tagT    issueDst;
dataT   issueA, issueB;

opcodeT headOp;
logic   headIsDiv, divInFlight, srcAReady, srcBReady, issueFire;

// ------------------------------
// head readiness
// ------------------------------
assign headOp    = qOp[head];
assign headIsDiv = (headOp == `OP_DIVU) || (headOp == `OP_REMU);
assign rdAddrA   = qSrcA[head];
assign rdAddrB   = qSrcB[head];
assign srcAReady = srcReady[qSrcA[head]];
assign srcBReady = (headOp == `OP_ADDI) || srcReady[qSrcB[head]];  // addi has no srcB

// divide still in our own issue register, divider has not seen it yet
assign divInFlight = issueValid && ((issueOp == `OP_DIVU) || (issueOp == `OP_REMU));

assign issueFire = (count != '0) && srcAReady && srcBReady
                && !(headIsDiv && (divBusy || divInFlight));

// destination goes not-ready as soon as the uop is accepted
assign clearValid = dispValid;
assign clearTag   = dispDst;

always_ff @(posedge clk) begin
    if (dispValid) begin
        qOp[tail]   <= dispOp;
        qDst[tail]  <= dispDst;
        qSrcA[tail] <= dispSrcA;
        qSrcB[tail] <= dispSrcB;
        qImm[tail]  <= dispImm;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        head       <= '0;
        tail       <= '0;
        count      <= '0;
        issueValid <= 1'b0;
    end else begin
        if (dispValid) tail <= tail + 1'b1;
        if (issueFire) head <= head + 1'b1;
        count      <= count + creditT'(dispValid) - creditT'(issueFire);
        issueValid <= issueFire;
    end
end

always_ff @(posedge clk) begin
    if (issueFire) begin
        issueOp  <= headOp;
        issueDst <= qDst[head];
        issueA   <= rdDataA;
        issueB   <= (headOp == `OP_ADDI) ? qImm[head] : rdDataB;
    end
end

assign issue.valid  = issueValid;
assign issue.op     = issueOp;
assign issue.dstTag = issueDst;
assign issue.opA    = issueA;
assign issue.opB    = issueB;
assign creditReturn = issueValid;   // entry left the queue

noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
    dispValid |-> count < creditT'(`EXEC_IQ_DEPTH));

noDstTagZero: assert property (@(posedge clk) disable iff (reset)
    dispValid |-> dispDst != '0);

endmodule

// File: design/regFile.sv
`include "execPort_consts.svh"

module regFile import execPkg::*;
(
    input  logic clk,
    input  logic reset,

    // operand reads for the queue head
    input  tagT  rdAddrA,
    input  tagT  rdAddrB,
    output dataT rdDataA,
    output dataT rdDataB,
    output logic [`EXEC_NUM_REGS-1:0] srcReady,

    input  logic clearValid,
    input  tagT  clearTag,

    input  logic wrValid,
    input  tagT  wrTag,
    input  dataT wrData
);

dataT regs [`EXEC_NUM_REGS];
logic [`EXEC_NUM_REGS-1:0] ready;

assign rdDataA  = regs[rdAddrA];
assign rdDataB  = regs[rdAddrB];
assign srcReady = ready;

// ------------------------------
// write port and ready tracking
// ------------------------------
always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
        ready <= '1;    // everything valid out of reset
    end else begin
        if (clearValid) begin
            ready[clearTag] <= 1'b0;
        end
        if (wrValid) begin
            regs[wrTag]  <= wrData;
            ready[wrTag] <= 1'b1;
        end
    end
end

// in-order dispatch means a tag is cleared long before its own result returns
noWriteClearClash: assert property (@(posedge clk) disable iff (reset)
    (wrValid && clearValid) |-> wrTag != clearTag);

// a result only lands on a tag that was waiting for it
writeOnlyPending: assert property (@(posedge clk) disable iff (reset)
    wrValid |-> !ready[wrTag]);

endmodule

// File: design/intAlu.sv
`include "execPort_consts.svh"

module intAlu import execPkg::*;
(
    input  logic clk,
    input  logic reset,

    execIssueIf.sink issue,

    output logic aluValid,
    output tagT  aluTag,
    output dataT aluResult
);

logic isAluOp;
dataT result;

always_comb begin
    isAluOp = 1'b1;
    result  = '0;
    case (issue.op)
        `OP_ADDI,
        `OP_ADD: result = issue.opA + issue.opB;   // opB already holds imm for addi
        `OP_SUB: result = issue.opA - issue.opB;
        `OP_AND: result = issue.opA & issue.opB;
        `OP_XOR: result = issue.opA ^ issue.opB;
        default: isAluOp = 1'b0;                   // divider's uop
    endcase
end

always_ff @(posedge clk) begin
    if (reset) aluValid <= 1'b0;
    else       aluValid <= issue.valid && isAluOp;
end

always_ff @(posedge clk) begin
    if (issue.valid && isAluOp) begin
        aluTag    <= issue.dstTag;
        aluResult <= result;
    end
end

endmodule

// File: design/divider.sv
`include "execPort_consts.svh"

module divider import execPkg::*;
(
    input  logic clk,
    input  logic reset,

    execIssueIf.sink issue,

    output logic divBusy,
    output logic divValid,
    output tagT  divTag,
    output dataT divResult,
    input  logic divGrant
);

divStateT state;
divCountT count;

dataT quo;      // dividend shifts out, quotient shifts in
dataT rem;
dataT divisor;
tagT  tag;
logic wantRem;

logic isDivOp;
logic [`EXEC_DATA_W:0] partial;
logic takeIt;

assign isDivOp = (issue.op == `OP_DIVU) || (issue.op == `OP_REMU);

// ------------------------------
// one restoring step per cycle
// ------------------------------
assign partial = {rem, quo[`EXEC_DATA_W-1]};
assign takeIt  = partial >= {1'b0, divisor};
// divisor of zero always subtracts: quotient all ones, remainder = dividend

always_ff @(posedge clk) begin
    if (reset) begin
        state <= IDLE;
        count <= '0;
    end else begin
        case (state)
            IDLE: if (issue.valid && isDivOp) begin
                state <= RUN;
                count <= '0;
            end
            RUN: begin
                count <= count + 1'b1;
                if (count == divCountT'(`EXEC_DIV_STEPS - 1)) state <= DONE;
            end
            DONE: if (divGrant) state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == IDLE && issue.valid && isDivOp) begin
        quo     <= issue.opA;
        rem     <= '0;
        divisor <= issue.opB;
        tag     <= issue.dstTag;
        wantRem <= issue.op == `OP_REMU;
    end else if (state == RUN) begin
        quo <= {quo[`EXEC_DATA_W-2:0], takeIt};
        rem <= takeIt ? dataT'(partial - {1'b0, divisor}) : dataT'(partial);
    end
end

assign divBusy   = state != IDLE;   // capture through grant
assign divValid  = state == DONE;
assign divTag    = tag;
assign divResult = wantRem ? rem : quo;

// queue gating must keep a second divide away until the grant
noDivWhileBusy: assert property (@(posedge clk) disable iff (reset)
    (issue.valid && isDivOp) |-> !divBusy);

endmodule

// File: design/writebackPort.sv
module writebackPort import execPkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic aluValid,
    input  tagT  aluTag,
    input  dataT aluResult,

    input  logic divValid,
    input  tagT  divTag,
    input  dataT divResult,
    output logic divGrant,

    output logic wbValid,
    output tagT  wbTag,
    output dataT wbResult
);

// alu never waits and divide takes the free slots
assign divGrant = divValid && !aluValid;

always_ff @(posedge clk) begin
    if (reset) wbValid <= 1'b0;
    else       wbValid <= aluValid || divValid;
end

always_ff @(posedge clk) begin
    if (aluValid) begin
        wbTag    <= aluTag;
        wbResult <= aluResult;
    end else if (divValid) begin
        wbTag    <= divTag;
        wbResult <= divResult;
    end
end

// a divide result that lost the port waits unchanged for its grant
divHeldUntilGrant: assert property (@(posedge clk) disable iff (reset)
    (divValid && !divGrant) |=> divValid && divTag == $past(divTag)
                                && divResult == $past(divResult));

endmodule

// File: design/execCore.sv
`include "execPort_consts.svh"

module execCore import execPkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   dispValid,
    input  opcodeT dispOp,
    input  tagT    dispDst,
    input  tagT    dispSrcA,
    input  tagT    dispSrcB,
    input  dataT   dispImm,
    output logic   creditReturn,

    output logic   wbValid,
    output tagT    wbTag,
    output dataT   wbResult
);

// ------------------------------
// internal wiring
// ------------------------------
tagT  rdAddrA, rdAddrB;
dataT rdDataA, rdDataB;
logic [`EXEC_NUM_REGS-1:0] srcReady;
logic clearValid;
tagT  clearTag;

logic divBusy, divValid, divGrant;
tagT  divTag;
dataT divResult;

logic aluValid;
tagT  aluTag;
dataT aluResult;

execIssueIf issueBus();

issueQueue iq (
    .clk(clk), .reset(reset),
    .dispValid(dispValid), .dispOp(dispOp), .dispDst(dispDst),
    .dispSrcA(dispSrcA), .dispSrcB(dispSrcB), .dispImm(dispImm),
    .creditReturn(creditReturn),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .srcReady(srcReady), .clearValid(clearValid), .clearTag(clearTag),
    .divBusy(divBusy), .issue(issueBus.source)
);

regFile rf (
    .clk(clk), .reset(reset),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .srcReady(srcReady), .clearValid(clearValid), .clearTag(clearTag),
    .wrValid(wbValid), .wrTag(wbTag), .wrData(wbResult)   // registered writeback
);

intAlu alu (
    .clk(clk), .reset(reset), .issue(issueBus.sink),
    .aluValid(aluValid), .aluTag(aluTag), .aluResult(aluResult)
);

divider div (
    .clk(clk), .reset(reset), .issue(issueBus.sink),
    .divBusy(divBusy), .divValid(divValid), .divTag(divTag),
    .divResult(divResult), .divGrant(divGrant)
);

writebackPort wb (
    .clk(clk), .reset(reset),
    .aluValid(aluValid), .aluTag(aluTag), .aluResult(aluResult),
    .divValid(divValid), .divTag(divTag), .divResult(divResult), .divGrant(divGrant),
    .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult)
);

endmodule

// File: dv/execCore_tb.sv
`include "execPort_consts.svh"

module execCore_tb import execPkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int CLK_PERIOD = 4;
localparam int MAX_UOPS   = 48;
localparam int FIELDS     = 6;                  // op dst srcA srcB imm expected
localparam logic [31:0] END_MARK = 32'hff;

logic   clk;
logic   reset;
logic   dispValid;
opcodeT dispOp;
tagT    dispDst;
tagT    dispSrcA;
tagT    dispSrcB;
dataT   dispImm;
logic   creditReturn;
logic   wbValid;
tagT    wbTag;
dataT   wbResult;

logic [31:0] stimMem [MAX_UOPS*FIELDS];
opcodeT uopOp   [MAX_UOPS];
tagT    uopDst  [MAX_UOPS];
tagT    uopSrcA [MAX_UOPS];
tagT    uopSrcB [MAX_UOPS];
dataT   uopImm  [MAX_UOPS];

dataT expByTag   [`EXEC_NUM_REGS];
logic inFile     [`EXEC_NUM_REGS];
logic dispatched [`EXEC_NUM_REGS];
logic written    [`EXEC_NUM_REGS];

int     numUops;
int     wbCount;
int     creditPulses;
int     mismatchErrors;
int     otherErrors;
creditT credits;        // dispatcher side view of free queue slots
logic   dispStarted;
logic   stimLoaded;

execCore dut (
    .clk(clk), .reset(reset),
    .dispValid(dispValid), .dispOp(dispOp), .dispDst(dispDst),
    .dispSrcA(dispSrcA), .dispSrcB(dispSrcB), .dispImm(dispImm),
    .creditReturn(creditReturn),
    .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// ------------------------------
// checks and reporting
// ------------------------------
task automatic reportProblem(input string what);
    $display("ERROR: %s (time %0t)", what, $time);
    otherErrors++;
endtask

task automatic checkResult(input tagT tag, input dataT expected, input dataT actual);
    if (actual !== expected) begin
        $display("FAILED result of tag %0d: expected %h, actual %h", tag, expected, actual);
        mismatchErrors++;
    end
endtask

task automatic checkCredits(input creditT expected, input creditT actual);
    if (actual !== expected) begin
        $display("FAILED credits after drain: expected %0d, actual %0d", expected, actual);
        mismatchErrors++;
    end
endtask

task automatic comparePulseTotal(input int expected, input int actual);
    if (actual != expected) begin
        $display("FAILED creditReturn pulse total: expected %0d, actual %0d", expected, actual);
        mismatchErrors++;
    end
endtask

task automatic reportOutstanding();
    for (int t = 0; t < `EXEC_NUM_REGS; t++) begin
        if (dispatched[t] && !written[t]) begin
            reportProblem($sformatf("result for tag %0d never arrived", t));
        end
    end
endtask

task automatic printSummary();
    $display("summary: %0d value mismatches, %0d other errors, %0d of %0d results seen",
             mismatchErrors, otherErrors, wbCount, numUops);
endtask

// ------------------------------
// stimulus
// ------------------------------
task automatic loadStim();
    int base;
    $readmemh("dv/execCore_stim.txt", stimMem);
    numUops = 0;
    while (numUops < MAX_UOPS && stimMem[numUops*FIELDS] != END_MARK) begin
        numUops++;
    end
    for (int i = 0; i < numUops; i++) begin
        base        = i * FIELDS;
        uopOp[i]    = opcodeT'(stimMem[base]);
        uopDst[i]   = tagT'(stimMem[base+1]);
        uopSrcA[i]  = tagT'(stimMem[base+2]);
        uopSrcB[i]  = tagT'(stimMem[base+3]);
        uopImm[i]   = stimMem[base+4];
        if (uopDst[i] == '0) begin
            reportProblem($sformatf("stim line %0d writes tag 0", i));
        end else if (inFile[uopDst[i]]) begin
            reportProblem($sformatf("stim file uses tag %0d twice", uopDst[i]));
        end
        inFile[uopDst[i]]   = 1'b1;
        expByTag[uopDst[i]] = stimMem[base+5];
    end
    if (numUops == 0) reportProblem("stim file holds no micro-ops");
    stimLoaded = 1'b1;
endtask

task automatic idleCycle();
    dispValid = 1'b0;
    @(posedge clk);
    #1;
endtask

task automatic dispatchUop(input int i);
    while (credits == '0) idleCycle();   // out of credits, hold off
    dispStarted = 1'b1;
    dispValid   = 1'b1;
    dispOp      = uopOp[i];
    dispDst     = uopDst[i];
    dispSrcA    = uopSrcA[i];
    dispSrcB    = uopSrcB[i];
    dispImm     = uopImm[i];
    credits--;
    dispatched[uopDst[i]] = 1'b1;
    @(posedge clk);
    #1;
    dispValid = 1'b0;
endtask

// outputs are registered, so the falling edge sees settled values
always @(negedge clk) begin
    if (reset || !dispStarted) begin
        if (wbValid === 1'b1 || creditReturn === 1'b1) begin
            reportProblem("writeback or credit seen before the first dispatch");
        end
    end else begin
        if (creditReturn) begin
            creditPulses++;
            if (credits == creditT'(`EXEC_IQ_DEPTH)) reportProblem("credit returned to a full pool");
            else credits++;
        end
        if (wbValid) begin
            if (!dispatched[wbTag]) begin
                reportProblem($sformatf("unexpected writeback for undispatched tag %0d", wbTag));
            end else if (written[wbTag]) begin
                reportProblem($sformatf("tag %0d written back twice", wbTag));
            end else begin
                written[wbTag] = 1'b1;
                wbCount++;
                checkResult(wbTag, expByTag[wbTag], wbResult);
            end
        end
    end
end

initial begin
    int gap;
    void'($urandom(32'heba));
    reset          = 1'b1;
    dispValid      = 1'b0;
    dispOp         = '0;
    dispDst        = '0;
    dispSrcA       = '0;
    dispSrcB       = '0;
    dispImm        = '0;
    credits        = creditT'(`EXEC_IQ_DEPTH);
    numUops        = 0;
    wbCount        = 0;
    creditPulses   = 0;
    mismatchErrors = 0;
    otherErrors    = 0;
    dispStarted    = 1'b0;
    stimLoaded     = 1'b0;
    for (int t = 0; t < `EXEC_NUM_REGS; t++) begin
        expByTag[t]   = '0;
        inFile[t]     = 1'b0;
        dispatched[t] = 1'b0;
        written[t]    = 1'b0;
    end
    loadStim();

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < numUops; i++) begin
        gap = ($urandom % 3 == 0) ? 1 + int'($urandom % 3) : 0;   // mostly back to back
        repeat (gap) idleCycle();
        dispatchUop(i);
    end

    wait (wbCount >= numUops && creditPulses >= numUops);
    repeat (20) @(posedge clk);     // catch stray writebacks

    checkCredits(creditT'(`EXEC_IQ_DEPTH), credits);
    comparePulseTotal(numUops, creditPulses);
    reportOutstanding();
    printSummary();
    if (mismatchErrors == 0 && otherErrors == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

// ------------------------------
// watchdog
// ------------------------------
initial begin
    wait (stimLoaded);
    #((numUops > 0 ? numUops : 1) * 60 * CLK_PERIOD);
    reportProblem("watchdog expired before all results came back");
    reportOutstanding();
    printSummary();
    $display("TEST FAIL");
    $finish;
end

endmodule

// File: dv/execCore_stim.txt
// columns (hex): opcode dst srcA srcB imm expected
// opcodes 0 addi 1 add 2 sub 3 and 4 xor 5 divu 6 remu, a line with opcode ff ends the list
0 01 00 00 00000064 00000064
0 02 00 00 fffffff9 fffffff9
0 03 00 00 12345678 12345678
0 04 00 00 00000007 00000007
1 05 02 04 00000000 00000000  // wraps to zero
2 06 04 01 00000000 ffffffa3
3 07 03 01 00000000 00000060
4 08 03 02 00000000 edcba981
0 09 08 00 0000007f edcbaa00
0 0a 00 00 000003e8 000003e8
5 0b 0a 04 00000000 0000008e  // 1000 / 7
1 0c 01 01 00000000 000000c8  // may overtake the divide
4 0d 0c 09 00000000 edcbaac8
6 0e 0a 04 00000000 00000006
2 0f 0b 04 00000000 00000087
5 10 01 00 00000000 ffffffff  // divide by zero
6 11 01 00 00000000 00000064
5 12 04 01 00000000 00000000  // divisor above dividend
6 13 04 01 00000000 00000007
5 14 02 04 00000000 24924923
0 15 14 00 00000001 24924924
3 16 0d 06 00000000 edcbaa80
2 17 00 01 00000000 ffffff9c
6 18 17 03 00000000 0123450c
0 19 18 00 ffffffff 0123450b
4 1a 15 11 00000000 24924940
ff 00 00 00 00000000 00000000

// File: execCore.f
+incdir+include
design/execPkg.sv
design/execIssueIf.sv
design/issueQueue.sv
design/regFile.sv
design/intAlu.sv
design/divider.sv
design/writebackPort.sv
design/execCore.sv
dv/execCore_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execCore testbench with Verilator
# all paths are relative to the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module execCore_tb -f execCore.f \
    -Mdir "$BUILD" -o execCore_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/execCore_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
